// File: build.f
src/sprite_pkg.sv
src/button_decoder.sv
src/axis_motion.sv
src/sprite_renderer.sv
src/sprite_top.sv
testbench/tb_clock.sv
testbench/sprite_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the sprite testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f build.f --top-module sprite_tb -o sprite_sim \
    && ./obj_dir/sprite_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulator run failed"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: src/axis_motion.sv
`timescale 1ns/10ps

module axis_motion
#(
    parameter sprite_pkg::coord_t pos_limit   = sprite_pkg::POS_LIMIT[0],  // upper bound
    parameter sprite_pkg::speed_t speed_start = sprite_pkg::SPEED_START,   // slowest countdown
    parameter sprite_pkg::speed_t speed_step  = sprite_pkg::SPEED_STEP,    // change per step
    parameter sprite_pkg::speed_t speed_min   = sprite_pkg::SPEED_MIN      // fastest countdown
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  sprite_pkg::axis_cmd_t cmd,       // neg/pos buttons for this axis
    input  logic                  grounded,  // low while airborne
    output sprite_pkg::coord_t    pos
);
    import sprite_pkg::*;

    motion_state_t state_reg, state_next;   // FSM state
    speed_t        time_reg, time_next;     // countdown to next step
    speed_t        start_reg, start_next;   // current start value, sets speed
    coord_t        pos_reg, pos_next;       // sprite position on this axis

    logic   can_neg;        // room to step toward zero
    logic   can_pos;        // room to step toward pos_limit
    logic   moving_neg;     // current direction is negative
    logic   same_btn;       // button for current direction
    logic   opp_btn;        // button against current direction
    logic   can_step;       // room in current direction
    coord_t step_pos;       // position one pixel on
    speed_t start_adj;      // start value after accel/brake

    // edge limits, the only boundary tests in the design
    assign can_neg = (pos_reg != '0);
    assign can_pos = (pos_reg < pos_limit - coord_t'(1));

    // fold both move states onto one datapath
    assign moving_neg = (state_reg == move_neg);
    assign same_btn   = moving_neg ? cmd.neg : cmd.pos;
    assign opp_btn    = moving_neg ? cmd.pos : cmd.neg;
    assign can_step   = moving_neg ? can_neg : can_pos;
    assign step_pos   = moving_neg ? pos_reg - coord_t'(1) : pos_reg + coord_t'(1);

    // momentum: speed up while held, brake against it, else keep
    always_comb
    begin
        if (same_btn && start_reg > speed_min)
            start_adj = start_reg - speed_step;     // shorter wait, faster
        else if (opp_btn && start_reg < speed_start)
            start_adj = start_reg + speed_step;     // longer wait, slower
        else
            start_adj = start_reg;
    end

    always_comb
    begin
        state_next = state_reg;
        time_next  = time_reg;
        start_next = start_reg;
        pos_next   = pos_reg;

        case (state_reg)
            idle:
            begin
                // exactly one button and a legal move
                if (cmd.neg && !cmd.pos && can_neg)
                begin
                    state_next = move_neg;
                    time_next  = speed_start;
                    start_next = speed_start;
                end
                else if (cmd.pos && !cmd.neg && can_pos)
                begin
                    state_next = move_pos;
                    time_next  = speed_start;
                    start_next = speed_start;
                end
            end

            move_neg, move_pos:
            begin
                if (time_reg != '0)
                    time_next = time_reg - speed_t'(1);    // count down
                else
                begin
                    if (can_step)
                        pos_next = step_pos;                // one pixel
                    start_next = start_adj;                 // new speed
                    time_next  = start_adj;                 // reload countdown
                end

                // on ground motion stops at once
                if (grounded && (!same_btn || opp_btn))
                    state_next = idle;
                // in the air only turn once braked to slowest speed
                else if (!grounded && opp_btn && start_reg >= speed_start)
                begin
                    state_next = moving_neg ? move_pos : move_neg;
                    time_next  = speed_start;
                    start_next = speed_start;
                end
            end

            default:
                state_next = idle;  // unused encoding
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_reg <= idle;
            time_reg  <= '0;
            start_reg <= '0;
            pos_reg   <= RESET_POS;     // start near screen middle
        end
        else
        begin
            state_reg <= state_next;
            time_reg  <= time_next;
            start_reg <= start_next;
            pos_reg   <= pos_next;
        end
    end

    assign pos = pos_reg;

endmodule

// File: src/button_decoder.sv
`timescale 1ns/10ps

module button_decoder
(
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         btn_up,
    input  logic                                         btn_left,
    input  logic                                         btn_right,
    input  logic                                         btn_down,
    output sprite_pkg::axis_cmd_t [sprite_pkg::NUM_AXES-1:0] cmd,
    output sprite_pkg::dir_t                             facing
);
    import sprite_pkg::*;

    dir_t facing_next;  // next facing value

    // per-axis commands, raw so both axis controllers see the same shape
    assign cmd[0].neg = btn_left;   // x axis
    assign cmd[0].pos = btn_right;
    assign cmd[1].neg = btn_up;     // y axis
    assign cmd[1].pos = btn_down;

    // later tests win, so up/down overrides left/right
    always_comb
    begin
        facing_next = facing;           // hold by default
        if (btn_left && !btn_right)
            facing_next = dir_left;     // opposite must be released
        if (btn_right && !btn_left)
            facing_next = dir_right;
        if (btn_up && !btn_down)
            facing_next = dir_up;
        if (btn_down && !btn_up)
            facing_next = dir_down;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            facing <= dir_right;        // sprite starts facing right
        else
            facing <= facing_next;
    end

endmodule

// File: src/sprite_pkg.sv
package sprite_pkg;

    // widths with a meaning
    typedef logic [9:0]  coord_t;   // pixel coordinate or sprite position
    typedef logic [11:0] rgb_t;     // 4 bits per channel, r g b
    typedef logic [19:0] speed_t;   // countdown / start value in clocks

    // facing, as last pressed
    typedef enum logic [1:0]
    {
        dir_left,
        dir_right,
        dir_up,
        dir_down
    } dir_t;

    // per-axis motion FSM
    typedef enum logic [1:0]
    {
        idle,       // no motion
        move_neg,   // toward zero (left or up)
        move_pos    // away from zero (right or down)
    } motion_state_t;

    // button pair for one axis
    typedef struct packed
    {
        logic neg;  // left on x, up on y
        logic pos;  // right on x, down on y
    } axis_cmd_t;

    localparam int NUM_AXES = 2;    // axis 0 is x, axis 1 is y

    // display and tile geometry
    localparam int MAX_X  = 640;
    localparam int MAX_Y  = 480;
    localparam int TILE_W = 16;
    localparam int TILE_H = 16;

    // upper position bound per axis, index 0 is x
    localparam coord_t [NUM_AXES-1:0] POS_LIMIT =
        {coord_t'(MAX_Y - TILE_H), coord_t'(MAX_X - TILE_W)};

    localparam coord_t RESET_POS = coord_t'(320);   // middle-ish of screen

    // momentum defaults, clocks between one-pixel steps
    localparam speed_t SPEED_START = speed_t'(800000);  // slowest
    localparam speed_t SPEED_STEP  = speed_t'(6000);    // change per step
    localparam speed_t SPEED_MIN   = speed_t'(500000);  // fastest

    localparam rgb_t  KEY_COLOR = 12'h6DE;              // transparent background colour
    localparam string ROM_FILE  = "src/sprite_rom.mem"; // 16x16 colour words, row major

endpackage

// File: src/sprite_renderer.sv
`timescale 1ns/10ps

module sprite_renderer
(
    input  logic               clk,
    input  logic               reset,
    input  sprite_pkg::coord_t pix_x,     // current scan pixel
    input  sprite_pkg::coord_t pix_y,
    input  sprite_pkg::coord_t sprite_x,  // top-left corner of sprite
    input  sprite_pkg::coord_t sprite_y,
    input  logic               video_on,  // display area active
    output sprite_pkg::rgb_t   rgb,
    output logic               pixel_on   // sprite pixel drawn, not key colour
);
    import sprite_pkg::*;

    rgb_t rom [TILE_W*TILE_H];    // one image, row major

    logic                        in_box;    // scan pixel inside the tile
    coord_t                      dx;        // offset from sprite corner
    coord_t                      dy;
    logic [$clog2(TILE_W)-1:0]   col;       // ROM column
    logic [$clog2(TILE_H)-1:0]   row;       // ROM row
    rgb_t                        rom_word;  // colour at row/col

    initial
    begin
        $readmemh(ROM_FILE, rom);
    end

    // box test against the 16x16 tile
    assign in_box = (pix_x >= sprite_x) && (pix_x < sprite_x + coord_t'(TILE_W)) &&
                    (pix_y >= sprite_y) && (pix_y < sprite_y + coord_t'(TILE_H));

    assign dx  = pix_x - sprite_x;
    assign dy  = pix_y - sprite_y;
    assign col = dx[$clog2(TILE_W)-1:0];    // only low bits matter inside box
    assign row = dy[$clog2(TILE_H)-1:0];

    assign rom_word = rom[{row, col}];

    // box result and ROM word registered together, one cycle latency
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rgb      <= '0;
            pixel_on <= 1'b0;
        end
        else if (video_on && in_box)
        begin
            rgb      <= rom_word;
            pixel_on <= (rom_word != KEY_COLOR);  // key colour is see-through
        end
        else
        begin
            rgb      <= '0;         // blank outside tile or during blanking
            pixel_on <= 1'b0;
        end
    end

endmodule

// File: src/sprite_rom.mem
// 16 rows top to bottom, 16 pixels left to right, 12-bit rgb words in hex
6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE
6DE 115 125 135 145 155 165 175 185 195 1A5 1B5 1C5 1D5 1E5 6DE
6DE 215 225 235 245 255 265 275 285 295 2A5 2B5 2C5 2D5 2E5 6DE
6DE 315 325 335 345 355 365 375 385 395 3A5 3B5 3C5 3D5 3E5 6DE
6DE 415 425 435 445 6DE 465 475 485 495 6DE 4B5 4C5 4D5 4E5 6DE
6DE 515 525 535 545 555 565 575 585 595 5A5 5B5 5C5 5D5 5E5 6DE
6DE 615 625 635 645 655 665 675 685 695 6A5 6B5 6C5 6D5 6E5 6DE
6DE 715 725 735 745 755 765 775 785 795 7A5 7B5 7C5 7D5 7E5 6DE
6DE 815 825 835 845 855 865 875 885 895 8A5 8B5 8C5 8D5 8E5 6DE
6DE 915 925 935 945 955 965 975 985 995 9A5 9B5 9C5 9D5 9E5 6DE
6DE A15 A25 A35 A45 A55 A65 A75 A85 A95 AA5 AB5 AC5 AD5 AE5 6DE
6DE B15 B25 B35 B45 B55 B65 B75 B85 B95 BA5 BB5 BC5 BD5 BE5 6DE
6DE C15 C25 C35 C45 C55 C65 C75 C85 C95 CA5 CB5 CC5 CD5 CE5 6DE
6DE D15 D25 D35 D45 D55 D65 D75 D85 D95 DA5 DB5 DC5 DD5 DE5 6DE
6DE E15 E25 E35 E45 E55 E65 E75 E85 E95 EA5 EB5 EC5 ED5 EE5 6DE
6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE 6DE

// File: src/sprite_top.sv
`timescale 1ns/10ps

module sprite_top
#(
    parameter sprite_pkg::speed_t speed_start = sprite_pkg::SPEED_START,  // slowest countdown
    parameter sprite_pkg::speed_t speed_step  = sprite_pkg::SPEED_STEP,   // change per step
    parameter sprite_pkg::speed_t speed_min   = sprite_pkg::SPEED_MIN     // fastest countdown
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               btn_up,
    input  logic               btn_left,
    input  logic               btn_right,
    input  logic               btn_down,
    input  logic               grounded,  // sprite standing on a platform
    input  logic               video_on,
    input  sprite_pkg::coord_t pix_x,
    input  sprite_pkg::coord_t pix_y,
    output sprite_pkg::rgb_t   rgb,
    output logic               pixel_on,
    output sprite_pkg::coord_t sprite_x,
    output sprite_pkg::coord_t sprite_y,
    output sprite_pkg::dir_t   facing
);
    import sprite_pkg::*;

    axis_cmd_t [NUM_AXES-1:0] cmd;    // button pair per axis
    coord_t    [NUM_AXES-1:0] pos;    // position per axis

    button_decoder u_decoder
    (
        .clk       (clk),
        .reset     (reset),
        .btn_up    (btn_up),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_down  (btn_down),
        .cmd       (cmd),
        .facing    (facing)
    );

    // one identical controller per axis, limit picked by index
    for (genvar i = 0; i < NUM_AXES; i++)
    begin : g_axis
        axis_motion
        #(
            .pos_limit   (POS_LIMIT[i]),
            .speed_start (speed_start),
            .speed_step  (speed_step),
            .speed_min   (speed_min)
        )
        u_axis
        (
            .clk      (clk),
            .reset    (reset),
            .cmd      (cmd[i]),
            .grounded (grounded),
            .pos      (pos[i])
        );
    end

    assign sprite_x = pos[0];
    assign sprite_y = pos[1];

    sprite_renderer u_renderer
    (
        .clk      (clk),
        .reset    (reset),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .sprite_x (pos[0]),
        .sprite_y (pos[1]),
        .video_on (video_on),
        .rgb      (rgb),
        .pixel_on (pixel_on)
    );

endmodule

// File: testbench/sprite_patterns.txt
# M buttons(up left right down) grounded hold settle exp_x exp_y exp_facing
# P pix_x pix_y video_on exp_rgb(hex) exp_pixel_on
# settle 1 releases all buttons with grounded high for one cycle before the check
# facing 0 left, 1 right, 2 up, 3 down
# state right after reset
M 0000 1 0 0 320 320 1
# grounded right hold, steps at cycles 42 79 112
M 0010 1 120 1 323 320 1
# nothing pressed, position holds
M 0000 1 30 1 323 320 1
# up hold moves y toward zero, steps at 42 79
M 1000 1 80 1 323 318 2
# up with left, both axes step once, up keeps the facing
M 1100 1 50 1 322 317 2
# airborne left, four steps, start value down to 24
M 0100 0 145 0 318 317 0
# right in the air, still drifting left while braking back to 40
M 0010 0 120 0 314 317 1
# reversed, moving right again
M 0010 0 90 1 316 317 1
# long left hold runs into the left edge
M 0100 1 8000 1 0 317 0
# pressing left at the edge does nothing
M 0100 1 60 1 0 317 0
# pixels, sprite box at (0, 317)
P 3 318 1 135 1
P 0 317 1 6DE 0
P 5 321 1 6DE 0
P 6 321 1 465 1
P 10 321 1 6DE 0
P 14 330 1 DE5 1
P 16 320 1 000 0
P 7 316 1 000 0
P 7 333 1 000 0
P 9 325 0 000 0
P 9 325 1 895 1
P 15 332 1 6DE 0

// File: testbench/sprite_tb.sv
`timescale 1ns/10ps

module sprite_tb;
    import sprite_pkg::*;

    localparam int    CLK_PERIOD   = 40;    // ns
    localparam int    DRIVE_DELAY  = 2;     // ns after rising edge
    localparam string PATTERN_FILE = "testbench/sprite_patterns.txt";

    // one parsed pattern line of either kind
    typedef struct packed
    {
        logic       is_motion;
        logic [3:0] btn;         // up left right down
        logic       grounded;
        int         hold;        // cycles the buttons are held
        logic       settle;      // release and settle one cycle before checking
        coord_t     exp_x;
        coord_t     exp_y;
        dir_t       exp_facing;
        coord_t     pix_x;
        coord_t     pix_y;
        logic       video_on;
        rgb_t       exp_rgb;
        logic       exp_on;
    } vector_t;

    logic    clk;
    logic    reset;
    logic    btn_up;
    logic    btn_left;
    logic    btn_right;
    logic    btn_down;
    logic    grounded;
    logic    video_on;
    coord_t  pix_x;
    coord_t  pix_y;
    rgb_t    rgb;
    logic    pixel_on;
    coord_t  sprite_x;
    coord_t  sprite_y;
    dir_t    facing;

    vector_t vectors[$];                  // whole pattern file
    rgb_t    rom_ref [TILE_W*TILE_H];     // expected sprite image
    coord_t  last_x;                      // sprite position from latest motion line
    coord_t  last_y;
    int      total_hold;                  // sum of hold cycles for the watchdog
    int      coord_errors;
    int      rgb_errors;
    int      dir_errors;
    int      bit_errors;
    int      other_errors;

    tb_clock #(.period(CLK_PERIOD), .reset_cycles(5)) u_clock (.clk(clk), .reset(reset));

    // small speeds keep the runs short
    sprite_top
    #(
        .speed_start (speed_t'(40)),
        .speed_step  (speed_t'(4)),
        .speed_min   (speed_t'(24))
    )
    dut
    (
        .clk       (clk),
        .reset     (reset),
        .btn_up    (btn_up),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_down  (btn_down),
        .grounded  (grounded),
        .video_on  (video_on),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .rgb       (rgb),
        .pixel_on  (pixel_on),
        .sprite_x  (sprite_x),
        .sprite_y  (sprite_y),
        .facing    (facing)
    );

    task automatic check_coord(input string name, input coord_t actual, input coord_t expected);
        if (actual !== expected)
        begin
            coord_errors++;
            $display("mismatch at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
        if (actual !== expected)
        begin
            rgb_errors++;
            $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_dir(input string name, input dir_t actual, input dir_t expected);
        if (actual !== expected)
        begin
            dir_errors++;
            $display("mismatch at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            bit_errors++;
            $display("mismatch at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // next stimulus point just after the rising edge
    task automatic wait_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic release_buttons();
        btn_up    = 1'b0;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        btn_down  = 1'b0;
        grounded  = 1'b1;   // on ground so a moving axis stops
    endtask

    task automatic load_patterns();
        int      fd;
        int      line_no;
        int      n;
        int      a, b, c, d, e, f, g;
        string   line;
        vector_t v;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("could not open the pattern file %s", PATTERN_FILE);
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0)
        begin
            line_no++;
            v = '0;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                               // blank or comment
            if (line.getc(0) == "M")
            begin
                n = $sscanf(line.substr(1, line.len()-1), "%b %d %d %d %d %d %d",
                            a, b, c, d, e, f, g);
                v.is_motion  = 1'b1;
                v.btn        = a[3:0];
                v.grounded   = b[0];
                v.hold       = c;
                v.settle     = d[0];
                v.exp_x      = coord_t'(e);
                v.exp_y      = coord_t'(f);
                v.exp_facing = dir_t'(g[1:0]);
                total_hold  += c;
                if (n != 7)
                    n = -1;
            end
            else
            begin
                n = $sscanf(line.substr(1, line.len()-1), "%d %d %d %h %d", a, b, c, d, e);
                v.pix_x    = coord_t'(a);
                v.pix_y    = coord_t'(b);
                v.video_on = c[0];
                v.exp_rgb  = rgb_t'(d);
                v.exp_on   = e[0];
                if (n != 5 || line.getc(0) != "P")
                    n = -1;
            end
            if (n == -1)
            begin
                other_errors++;
                $display("pattern line %0d is malformed and was skipped", line_no);
            end
            else
                vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic run_motion(input vector_t v);
        btn_up    = v.btn[3];
        btn_left  = v.btn[2];
        btn_right = v.btn[1];
        btn_down  = v.btn[0];
        grounded  = v.grounded;
        repeat (v.hold)
            wait_edge();
        if (v.settle)
        begin
            release_buttons();
            wait_edge();        // settle edge drops the axis to idle
        end
        check_coord("sprite_x", sprite_x, v.exp_x);
        check_coord("sprite_y", sprite_y, v.exp_y);
        check_dir("facing", facing, v.exp_facing);
        last_x = v.exp_x;
        last_y = v.exp_y;
    endtask

    task automatic run_pixel(input vector_t v);
        logic   in_box;
        logic   ref_on;
        coord_t dx;
        coord_t dy;
        rgb_t   ref_word;
        pix_x    = v.pix_x;
        pix_y    = v.pix_y;
        video_on = v.video_on;
        dx       = v.pix_x - last_x;
        dy       = v.pix_y - last_y;
        in_box   = (v.pix_x >= last_x) && (v.pix_x < last_x + coord_t'(TILE_W)) &&
                   (v.pix_y >= last_y) && (v.pix_y < last_y + coord_t'(TILE_H));
        ref_word = (v.video_on && in_box) ? rom_ref[{dy[3:0], dx[3:0]}] : '0;
        ref_on   = v.video_on && in_box && (ref_word != KEY_COLOR);   // key colour hidden
        if (v.exp_rgb !== ref_word || v.exp_on !== ref_on)
        begin
            other_errors++;
            $display("pixel (%0d, %0d) in the pattern file disagrees with the ROM image",
                     v.pix_x, v.pix_y);
        end
        wait_edge();            // output registered one cycle later
        check_rgb("rgb", rgb, v.exp_rgb);
        check_bit("pixel_on", pixel_on, v.exp_on);
    endtask

    task automatic idle_gap(input int cycles);
        release_buttons();
        video_on = 1'b0;
        repeat (cycles)
            wait_edge();
    endtask

    initial
    begin
        int      wd_time;
        int      total;
        vector_t v;
        btn_up       = 1'b0;
        btn_left     = 1'b0;
        btn_right    = 1'b0;
        btn_down     = 1'b0;
        grounded     = 1'b1;
        video_on     = 1'b1;            // visible pixel during reset
        pix_x        = coord_t'(321);   // inside the tile at the reset position
        pix_y        = coord_t'(321);
        last_x       = RESET_POS;
        last_y       = RESET_POS;
        total_hold   = 0;
        coord_errors = 0;
        rgb_errors   = 0;
        dir_errors   = 0;
        bit_errors   = 0;
        other_errors = 0;
        void'($urandom(61965));
        $readmemh(ROM_FILE, rom_ref);
        load_patterns();

        wd_time = (total_hold + 200) * CLK_PERIOD;     // holds plus settle, gaps and reset
        fork
            begin
                #(wd_time);
                $display("timeout: the run did not end within %0d ns", wd_time);
                $display("Simulation failed");
                $finish;
            end
        join_none

        @(negedge reset);
        check_rgb("rgb", rgb, '0);
        check_bit("pixel_on", pixel_on, 1'b0);
        video_on = 1'b0;
        foreach (vectors[i])
        begin
            v = vectors[i];
            if (v.is_motion)
                run_motion(v);
            else
                run_pixel(v);
            if (!v.is_motion || v.settle)
                idle_gap(int'($urandom_range(3, 0)));  // axes idle so the gap moves nothing
        end

        total = coord_errors + rgb_errors + dir_errors + bit_errors + other_errors;
        $display("errors: coord %0d, rgb %0d, facing %0d, pixel_on %0d, other %0d",
                 coord_errors, rgb_errors, dir_errors, bit_errors, other_errors);
        if (total == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
#(
    parameter int period       = 40,   // ns
    parameter int reset_cycles = 5     // rising edges held in reset
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(period/2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b0;   // released at the stimulus offset
    end

endmodule
